// File: vlog.f
+incdir+hw
hw/soc_pkg.sv
hw/data_ram.sv
hw/ps2_receiver.sv
hw/key_ctrl_regs.sv
hw/console_tx.sv
hw/periph_top.sv
bench/tb_clock_gen.sv
bench/periph_checker.sv
bench/periph_tb.sv

// File: Bender.yml
package:
  name: periph_soc

export_include_dirs:
  - hw

sources:
  - files:
      - hw/soc_pkg.sv
      - hw/data_ram.sv
      - hw/ps2_receiver.sv
      - hw/key_ctrl_regs.sv
      - hw/console_tx.sv
      - hw/periph_top.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/periph_checker.sv
      - bench/periph_tb.sv

// File: bench/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module periph_tb
    import soc_pkg::*;
();

    // PS/2 half period in system clocks
    localparam int PS2_HALF    = 12;
    localparam int PS2_FRAME   = 22 * PS2_HALF + 2;
    localparam int TX_FRAME    = 10 * `CON_BIT_CLKS;
    // Prefill, full readback, random writes with reads, register accesses
    localparam int BUS_CYCLES  = 2 * (2 * `RAM_WORDS + 2 * 40 + 40);
    localparam int TEST_CYCLES = BUS_CYCLES + 6 * PS2_FRAME + 3 * TX_FRAME + 64;
    localparam int WD_CYCLES   = TEST_CYCLES + TEST_CYCLES / 4 + 500;

    logic     CLOCK_50;
    logic     KEY0;
    bus_req_t bus_req;
    word_t    bus_rdata;
    irq_vec_t irq_vec;
    logic     irq_ack;
    logic     ps2_clk;
    logic     ps2_dat;
    logic     con_txd;

    int       errors = 0;
    logic     rd_pend = 1'b0;
    word_t    exp_q[$];
    addr_t    addr_q[$];
    byte_t    rx_q[$];
    word_t    shadow [0:`RAM_WORDS-1];

    tb_clock_gen u_clk_gen (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    periph_top UUT (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus_req   (bus_req),
        .bus_rdata (bus_rdata),
        .irq_vec   (irq_vec),
        .irq_ack   (irq_ack),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .con_txd   (con_txd)
    );

    // Byte-lane merge of a write into the old word
    function automatic word_t ref_merge(word_t old, word_t wd, bus_size_e sz,
                                        logic [1:0] off);
        word_t r;
        r = old;
        case (sz)
            SIZE_BYTE: r[8*off +: 8] = wd[7:0];
            SIZE_HALF: r[16*off[1] +: 16] = wd[15:0];
            default:   r = wd;
        endcase
        return r;
    endfunction

    // Multiplicative hash, every address bit matters
    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    // Any code except the F0 break prefix
    function automatic byte_t rand_code();
        return byte_t'($urandom_range(8'hEF, 8'h01));
    endfunction

    task automatic bus_write(input addr_t addr, input word_t data, input bus_size_e size);
        @(posedge CLOCK_50);
        bus_req.addr  <= addr;
        bus_req.wdata <= data;
        bus_req.size  <= size;
        bus_req.wr    <= 1'b1;
        @(posedge CLOCK_50);
        bus_req.wr    <= 1'b0;
    endtask

    // Queue the expected value, the compare process checks it
    task automatic check_read(input addr_t addr, input word_t exp);
        exp_q.push_back(exp);
        addr_q.push_back(addr);
        @(posedge CLOCK_50);
        bus_req.addr <= addr;
        bus_req.rd   <= 1'b1;
        @(posedge CLOCK_50);
        bus_req.rd   <= 1'b0;
    endtask

    // Start, 8 data LSB first, parity, stop
    task automatic ps2_send(input byte_t code, input bit good_parity);
        logic [10:0] frame;
        logic        par;
        par   = good_parity ? ~^code : ^code;
        frame = {1'b1, par, code, 1'b0};
        @(posedge CLOCK_50);
        for (int i = 0; i < 11; i++) begin
            ps2_dat <= frame[i];
            repeat (PS2_HALF) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (PS2_HALF) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
        ps2_dat <= 1'b1;
    endtask

    task automatic check_irq(input irq_vec_t exp);
        @(negedge CLOCK_50);
        assert (irq_vec === exp) else begin
            errors++;
            $display("ERR t=%0t irq_vec: expected %h, got %h", $time, exp, irq_vec);
        end
    endtask

    // Wait for one decoded console byte, bounded by a frame and some slack
    task automatic wait_console(input byte_t exp);
        int    waited;
        byte_t got;
        waited = 0;
        while (rx_q.size() == 0 && waited < 12 * `CON_BIT_CLKS) begin
            @(negedge CLOCK_50);
            waited++;
        end
        assert (rx_q.size() != 0) else begin
            errors++;
            $display("No console frame seen on con_txd within %0d cycles", waited);
        end
        if (rx_q.size() != 0) begin
            got = rx_q.pop_front();
            assert (got === exp) else begin
                errors++;
                $display("ERR t=%0t con_txd: expected %h, got %h", $time, exp, got);
            end
        end
    endtask

    // Read strobe seen by the DUT last edge
    always @(posedge CLOCK_50) begin
        rd_pend <= bus_req.rd;
    end

    // Read data is stable at the falling edge after the read
    always @(negedge CLOCK_50) begin : compare_reads
        word_t exp;
        addr_t addr;
        if (rd_pend) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("Read data returned with no expected value queued");
            end
            if (exp_q.size() > 0) begin
                exp  = exp_q.pop_front();
                addr = addr_q.pop_front();
                assert (bus_rdata === exp) else begin
                    errors++;
                    $display("ERR t=%0t bus_rdata @%h: expected %h, got %h",
                             $time, addr, exp, bus_rdata);
                end
            end
        end
    end

    // 8N1 decoder, samples mid-bit on falling clock edges
    initial begin : serial_monitor
        byte_t rx;
        wait (KEY0 === 1'b1);
        forever begin
            @(negedge con_txd);
            repeat (`CON_BIT_CLKS / 2) @(negedge CLOCK_50);
            assert (con_txd === 1'b0) else begin
                errors++;
                $display("Console start bit did not hold low at %0t", $time);
            end
            for (int b = 0; b < 8; b++) begin
                repeat (`CON_BIT_CLKS) @(negedge CLOCK_50);
                rx[b] = con_txd;
            end
            repeat (`CON_BIT_CLKS) @(negedge CLOCK_50);
            assert (con_txd === 1'b1) else begin
                errors++;
                $display("Console stop bit low at %0t", $time);
            end
            rx_q.push_back(rx);
        end
    end

    // Watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge CLOCK_50);
        $display("Timeout: tests did not finish within %0d cycles", WD_CYCLES);
        $display("Errors: %0d", errors + UUT.u_checker.assert_fails);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int        idx;
        addr_t     addr;
        word_t     wd;
        bus_size_e sz;
        logic [1:0] off;
        byte_t     code;
        byte_t     ch;

        void'($urandom(12));
        bus_req = '0;
        irq_ack = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        wait (KEY0 === 1'b1);
        @(posedge CLOCK_50);

        // RAM prefill with a known pattern
        for (int i = 0; i < `RAM_WORDS; i++) begin
            addr      = `RAM_BASE + 4 * i;
            shadow[i] = fill_word(addr);
            bus_write(addr, shadow[i], SIZE_WORD);
        end

        // Random sized writes, each read back
        for (int n = 0; n < 40; n++) begin
            idx = $urandom_range(`RAM_WORDS - 1, 0);
            sz  = bus_size_e'($urandom_range(2, 0));
            off = 2'($urandom_range(3, 0));
            if (sz == SIZE_HALF) begin
                off[0] = 1'b0;
            end else if (sz == SIZE_WORD) begin
                off = 2'b00;
            end
            wd          = $urandom;
            addr        = `RAM_BASE + 4 * idx;
            shadow[idx] = ref_merge(shadow[idx], wd, sz, off);
            bus_write(addr + off, wd, sz);
            check_read(addr, shadow[idx]);
        end

        // Unmapped reads and writes
        check_read(32'h0000_1000, 32'd0);
        check_read(32'h0000_3000, 32'd0);
        check_read(32'h0000_800C, 32'd0);
        bus_write(32'h0000_3000, 32'hDEAD_BEEF, SIZE_WORD);
        bus_write(32'h0000_1FFC, 32'h1234_5678, SIZE_WORD);
        for (int i = 0; i < `RAM_WORDS; i++) begin
            check_read(`RAM_BASE + 4 * i, shadow[i]);
        end

        // Make code, then pending cleared by the data read
        code = rand_code();
        ps2_send(code, 1'b1);
        check_irq(4'd0);
        check_read(`KEY_STAT, 32'd1);
        check_read(`KEY_DATA, {24'd0, code});
        check_read(`KEY_STAT, 32'd0);

        // Break prefix then code
        code = rand_code();
        ps2_send(8'hF0, 1'b1);
        ps2_send(code, 1'b1);
        check_read(`KEY_STAT, 32'd2);
        check_read(`KEY_DATA, {24'd0, code});

        // Bad parity frame is dropped
        ps2_send(rand_code(), 1'b0);
        check_read(`KEY_STAT, 32'd2);
        check_read(`KEY_DATA, {24'd0, code});

        // Interrupt enabled, held until acknowledge
        bus_write(`KEY_CTRL, 32'd1, SIZE_WORD);
        check_read(`KEY_CTRL, 32'd1);
        code = rand_code();
        ps2_send(code, 1'b1);
        repeat (20) check_irq(`KEY_IRQ_VEC);
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        repeat (5) check_irq(4'd0);
        check_read(`KEY_STAT, 32'd1);
        check_read(`KEY_DATA, {24'd0, code});

        // Interrupt disabled, pending still set
        bus_write(`KEY_CTRL, 32'd0, SIZE_WORD);
        ps2_send(rand_code(), 1'b1);
        repeat (20) check_irq(4'd0);
        check_read(`KEY_STAT, 32'd1);

        // Console byte, busy right after, second write dropped
        ch = byte_t'($urandom);
        bus_write(`CON_DATA, {24'd0, ch}, SIZE_WORD);
        check_read(`CON_STAT, 32'd1);
        bus_write(`CON_DATA, {24'd0, ~ch}, SIZE_WORD);
        wait_console(ch);
        repeat (12 * `CON_BIT_CLKS) @(negedge CLOCK_50);
        assert (rx_q.size() == 0) else begin
            errors++;
            $display("Console sent a byte that was written while busy");
        end
        check_read(`CON_STAT, 32'd0);

        repeat (4) @(posedge CLOCK_50);
        errors += UUT.u_checker.assert_fails;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/periph_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module periph_checker
    import soc_pkg::*;
(
    input logic     CLOCK_50,
    input logic     KEY0,
    input bus_req_t bus_req,
    input irq_vec_t irq_vec,
    input logic     busy,
    input logic     txd
);

    // Failed assertions, read by the testbench at the end
    int assert_fails = 0;

    // One strobe per cycle
    rd_wr_exclusive: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_req.rd && bus_req.wr))
        else begin
            assert_fails++;
            $error("rd and wr asserted in the same cycle");
        end

    // Idle serial line stays high
    txd_idle_high: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !busy |-> txd)
        else begin
            assert_fails++;
            $error("con_txd low while console is not busy");
        end

    // Only the keyboard vector exists
    irq_vec_legal: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (irq_vec == 4'd0) || (irq_vec == `KEY_IRQ_VEC))
        else begin
            assert_fails++;
            $error("irq_vec holds an unknown vector %0d", irq_vec);
        end

endmodule

bind periph_top periph_checker u_checker (
    .CLOCK_50 (CLOCK_50),
    .KEY0     (KEY0),
    .bus_req  (bus_req),
    .irq_vec  (irq_vec),
    .busy     (con_busy),
    .txd      (con_txd)
);

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);

    // 8 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // Reset held low for 4 rising edges
    initial begin
        KEY0 = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/periph_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module periph_top
    import soc_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  bus_req_t bus_req,
    output word_t    bus_rdata,
    output irq_vec_t irq_vec,
    input  logic     irq_ack,
    input  logic     ps2_clk,
    input  logic     ps2_dat,
    output logic     con_txd
);

    logic     ram_sel;
    logic     key_sel;
    logic     con_sel;
    logic     con_start;
    logic     con_busy;
    word_t    ram_rdata;
    word_t    key_rdata;
    word_t    reg_rdata;
    word_t    reg_rdata_q;
    logic     ram_src_q;
    key_evt_t key_evt;

    // One-hot address decode
    assign ram_sel = (bus_req.addr >= `RAM_BASE) &&
                     (bus_req.addr < `RAM_BASE + 4 * `RAM_WORDS);
    assign key_sel = (bus_req.addr == `KEY_DATA) || (bus_req.addr == `KEY_STAT) ||
                     (bus_req.addr == `KEY_CTRL);
    assign con_sel = (bus_req.addr == `CON_DATA) || (bus_req.addr == `CON_STAT);

    // Console data write kicks off a frame
    assign con_start = con_sel & bus_req.wr & (bus_req.addr == `CON_DATA);

    data_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .bus_req  (bus_req),
        .sel      (ram_sel),
        .rdata    (ram_rdata)
    );

    ps2_receiver u_ps2 (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .evt      (key_evt)
    );

    key_ctrl_regs u_key (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus_req  (bus_req),
        .sel      (key_sel),
        .evt      (key_evt),
        .rdata    (key_rdata),
        .irq_vec  (irq_vec),
        .irq_ack  (irq_ack)
    );

    console_tx u_con (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (con_start),
        .data     (bus_req.wdata[7:0]),
        .busy     (con_busy),
        .txd      (con_txd)
    );

    // Register side of the read mux, unmapped gives zero
    always_comb begin
        if (key_sel) begin
            reg_rdata = key_rdata;
        end else if (con_sel && bus_req.addr == `CON_STAT) begin
            reg_rdata = {31'd0, con_busy};
        end else begin
            reg_rdata = '0;
        end
    end

    // Remember the source of the last read so the data holds between reads
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            reg_rdata_q <= '0;
            ram_src_q   <= 1'b0;
        end else if (bus_req.rd) begin
            reg_rdata_q <= reg_rdata;
            ram_src_q   <= ram_sel;
        end
    end

    // RAM output is already registered
    assign bus_rdata = ram_src_q ? ram_rdata : reg_rdata_q;

endmodule

`default_nettype wire

// File: hw/console_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module console_tx
    import soc_pkg::*;
(
    input  logic  CLOCK_50,
    input  logic  KEY0,
    input  logic  start,
    input  byte_t data,
    output logic  busy,
    output logic  txd
);

    localparam int CW = $clog2(`CON_BIT_CLKS);

    tx_state_e        state;
    logic [CW-1:0]    clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;
    logic             bit_end;

    // Last clock of the current bit
    assign bit_end = (clk_cnt == CW'(`CON_BIT_CLKS - 1));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift   <= '0;
        end else begin
            if (state == TX_IDLE) begin
                // Writes while busy never reach here
                if (start) begin
                    shift   <= data;
                    clk_cnt <= '0;
                    state   <= TX_START;
                end
            end else begin
                clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                if (bit_end) begin
                    case (state)
                        TX_START: begin
                            bit_idx <= '0;
                            state   <= TX_DATA;
                        end
                        TX_DATA: begin
                            // LSB first
                            shift   <= shift >> 1;
                            bit_idx <= bit_idx + 3'd1;
                            if (bit_idx == 3'd7) begin
                                state <= TX_STOP;
                            end
                        end
                        default: state <= TX_IDLE;
                    endcase
                end
            end
        end
    end

    assign busy = (state != TX_IDLE);

    // Line idles high, start bit low, stop bit high
    assign txd = (state == TX_START) ? 1'b0 :
                 (state == TX_DATA)  ? shift[0] : 1'b1;

endmodule

`default_nettype wire

// File: hw/key_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module key_ctrl_regs
    import soc_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  bus_req_t bus_req,
    input  logic     sel,
    input  key_evt_t evt,
    output word_t    rdata,
    output irq_vec_t irq_vec,
    input  logic     irq_ack
);

    byte_t key_code;
    logic  released;
    logic  pending;
    logic  enable;
    logic  irq_armed;
    logic  make_evt;
    logic  data_rd;
    logic  ctrl_wr;

    // Key press, not a release
    assign make_evt = evt.valid & ~evt.released;
    assign data_rd  = sel & bus_req.rd & (bus_req.addr == `KEY_DATA);
    assign ctrl_wr  = sel & bus_req.wr & (bus_req.addr == `KEY_CTRL);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code  <= '0;
            released  <= 1'b0;
            pending   <= 1'b0;
            enable    <= 1'b0;
            irq_armed <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                enable <= bus_req.wdata[0];
            end
            // New event wins over a data read in the same cycle
            if (evt.valid) begin
                key_code <= evt.code;
                released <= evt.released;
            end
            if (make_evt) begin
                pending <= 1'b1;
            end else if (data_rd) begin
                pending <= 1'b0;
            end
            // Request sent once per event, dropped on acknowledge
            if (make_evt && enable) begin
                irq_armed <= 1'b1;
            end else if (irq_ack) begin
                irq_armed <= 1'b0;
            end
        end
    end

    assign irq_vec = irq_armed ? `KEY_IRQ_VEC : 4'd0;

    // Read data, registered in the top level
    always_comb begin
        rdata = '0;
        if (sel) begin
            case (bus_req.addr)
                `KEY_DATA: rdata = {24'd0, key_code};
                `KEY_STAT: rdata = {30'd0, released, pending};
                `KEY_CTRL: rdata = {31'd0, enable};
                default:   rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver
    import soc_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     ps2_clk,
    input  logic     ps2_dat,
    output key_evt_t evt
);

    logic [2:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_fall;
    logic        bit_in;
    ps2_state_e  state;
    logic [2:0]  bit_cnt;
    byte_t       shift;
    logic        parity;
    logic        brk;
    logic        frame_ok;

    // Two flops for metastability, third one for edge detection
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];
    assign bit_in   = dat_sync[1];

    // Odd parity over data and parity bit, stop bit must be high
    assign frame_ok = (^shift ^ parity) & bit_in;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= PS2_IDLE;
            bit_cnt <= '0;
            shift   <= '0;
            parity  <= 1'b0;
            brk     <= 1'b0;
            evt     <= '0;
        end else begin
            evt.valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    PS2_IDLE: begin
                        // Start bit is low
                        if (!bit_in) begin
                            bit_cnt <= '0;
                            state   <= PS2_DATA;
                        end
                    end
                    PS2_DATA: begin
                        // LSB first
                        shift   <= {bit_in, shift[7:1]};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PS2_PARITY;
                        end
                    end
                    PS2_PARITY: begin
                        parity <= bit_in;
                        state  <= PS2_STOP;
                    end
                    default: begin
                        state <= PS2_IDLE;
                        if (frame_ok) begin
                            if (shift == 8'hF0) begin
                                // Break prefix, wait for the code that follows
                                brk <= 1'b1;
                            end else begin
                                evt.valid    <= 1'b1;
                                evt.released <= brk;
                                evt.code     <= shift;
                                brk          <= 1'b0;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module data_ram
    import soc_pkg::*;
(
    input  logic     CLOCK_50,
    input  bus_req_t bus_req,
    input  logic     sel,
    output word_t    rdata
);

    localparam int AW = $clog2(`RAM_WORDS);

    word_t           mem [0:`RAM_WORDS-1];
    logic [AW-1:0]   widx;
    logic [3:0]      lane_en;
    word_t           lane_data;

    // Window is aligned to its size, so low address bits index the array
    assign widx = bus_req.addr[AW+1:2];

    // Lane enables and replicated write data per size
    always_comb begin
        case (bus_req.size)
            SIZE_BYTE: begin
                lane_en   = 4'b0001 << bus_req.addr[1:0];
                lane_data = {4{bus_req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                lane_en   = bus_req.addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{bus_req.wdata[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = bus_req.wdata;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (sel && bus_req.wr) begin
            for (int i = 0; i < 4; i++) begin
                // Only enabled lanes change
                if (lane_en[i]) begin
                    mem[widx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
        // Registered read, held until the next RAM read
        if (sel && bus_req.rd) begin
            rdata <= mem[widx];
        end
    end

endmodule

`default_nettype wire

// File: hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Zero means no request pending
    typedef logic [3:0]  irq_vec_t;

    // Access size code, same encoding as the CPU core
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2
    } bus_size_e;

    // One bus request per cycle, rd and wr are strobes
    typedef struct packed {
        addr_t     addr;
        word_t     wdata;
        bus_size_e size;
        logic      rd;
        logic      wr;
    } bus_req_t;

    // Decoded keyboard event, valid is a single-cycle pulse
    typedef struct packed {
        logic  valid;
        logic  released;
        byte_t code;
    } key_evt_t;

    typedef enum logic [1:0] {PS2_IDLE, PS2_DATA, PS2_PARITY, PS2_STOP} ps2_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage

`default_nettype wire

// File: hw/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// RAM window, 4 KB of 32-bit words
`define RAM_BASE      32'h0000_2000
`define RAM_WORDS     1024

// Keyboard register block
`define KEY_DATA      32'h0000_8000
`define KEY_STAT      32'h0000_8004
`define KEY_CTRL      32'h0000_8008

// Serial console registers
`define CON_DATA      32'h0000_9000
`define CON_STAT      32'h0000_9004

// Clocks per serial bit, kept short for simulation
`define CON_BIT_CLKS  16

// Vector number shown while the keyboard interrupt is armed
`define KEY_IRQ_VEC   4'd1

`endif
